// File: hw/vdp_pkg.sv
`default_nettype none

package vdp_pkg;

    // Number of entries in the control register file
    localparam int NUM_REGS = 16;

    // I/O decode descriptor, the device answers when (addr & mask) == port
    typedef struct packed {
        logic       enable;
        logic [7:0] port;
        logic [7:0] mask;
    } io_device_t;

    // One CPU I/O cycle, req is high for a single clock
    typedef struct packed {
        logic       req;
        logic       wr;
        logic [7:0] addr;
        logic [7:0] wdata;
    } cpu_req_t;

    // Second control byte, bit 7 tells which of the two views applies
    typedef union packed {
        struct packed {
            logic       is_reg;
            logic [2:0] unused;
            logic [3:0] reg_num;
        } reg_view;
        struct packed {
            logic       is_reg;
            logic       write_mode;
            logic [5:0] addr_hi;
        } addr_view;
    } ctrl_word_u;

    // Strobed VRAM request from the command port to the VRAM port
    typedef struct packed {
        logic        wr_stb;
        logic        rd_stb;
        logic [16:0] addr;
        logic [7:0]  data;
    } vram_cmd_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic       hs;
        logic       vs;
        logic       de;
        logic       hblank;
        logic       vblank;
        logic       ce_pix;
    } video_out_t;

    // External VRAM bus, two 64K banks share address and data
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        we_lo;
        logic        we_hi;
    } vram_bus_t;

    // Fixed 24-bit RGB palette, the usual power-on colours of the chip
    localparam logic [23:0] PALETTE [16] = '{
        24'h000000, 24'h000000, 24'h24DB24, 24'h6DFF6D,
        24'h2424FF, 24'h496DFF, 24'hB62424, 24'h49DBFF,
        24'hFF2424, 24'hFF6D6D, 24'hDBDB24, 24'hDBDB92,
        24'h249224, 24'hDB49B6, 24'hB6B6B6, 24'hFFFFFF
    };

endpackage

`default_nettype wire

// File: hw/vdp_cmd_port.sv
`default_nettype none

module vdp_cmd_port (
    input  logic                cpu_bus,
    input  logic                arst_n,
    input  vdp_pkg::cpu_req_t   cpu,
    input  vdp_pkg::io_device_t io_device,
    input  logic [7:0]          rd_data,
    input  logic                rd_valid,
    input  logic [7:0]          status,
    output logic [7:0]          rdata,
    output logic                status_rd,
    output vdp_pkg::vram_cmd_t  vram_cmd,
    output logic [3:0]          backdrop,
    output logic                irq_en
);
    import vdp_pkg::*;

    logic        sel;
    logic        acc;
    logic        ctrl_wr;
    logic        data_wr;
    logic        data_rd;
    logic        second_q;
    logic [7:0]  latch_q;
    ctrl_word_u  ctrl_w;
    logic [16:0] ptr_q;
    logic [16:0] setup_ptr;
    logic [7:0]  rd_buf_q;
    logic [7:0]  regs [NUM_REGS];
    logic        wr_stb_q;
    logic        rd_stb_q;
    logic [16:0] cmd_addr_q;
    logic [7:0]  cmd_data_q;

    // Port match, the descriptor enable keeps a disabled device silent
    assign sel = io_device.enable && ((cpu.addr & io_device.mask) == io_device.port);
    assign acc = sel && cpu.req;

    // Address bit 0 picks the control port (1) or the data port (0)
    assign ctrl_wr   = acc &&  cpu.wr &&  cpu.addr[0];
    assign data_wr   = acc &&  cpu.wr && !cpu.addr[0];
    assign data_rd   = acc && !cpu.wr && !cpu.addr[0];
    assign status_rd = acc && !cpu.wr &&  cpu.addr[0];

    // Read data is valid in the req cycle, idle bus floats high
    assign rdata = (sel && !cpu.wr) ? (cpu.addr[0] ? status : rd_buf_q) : 8'hFF;

    // The second control byte is decoded through the union views
    assign ctrl_w = cpu.wdata;

    // Bits 16:14 of a new pointer come from register 14
    assign setup_ptr = {regs[14][2:0], ctrl_w.addr_view.addr_hi, latch_q};

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            second_q <= 1'b0;
            ptr_q    <= '0;
            wr_stb_q <= 1'b0;
            rd_stb_q <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            wr_stb_q <= 1'b0;
            rd_stb_q <= 1'b0;
            // Any data access or status read restarts the byte sequence
            if (status_rd || data_wr || data_rd) begin
                second_q <= 1'b0;
            end
            if (data_wr) begin
                wr_stb_q <= 1'b1;
                ptr_q    <= ptr_q + 17'd1;
            end
            // A data read returns the old buffer and fetches the next byte
            if (data_rd) begin
                rd_stb_q <= 1'b1;
                ptr_q    <= ptr_q + 17'd1;
            end
            if (ctrl_wr) begin
                if (!second_q) begin
                    second_q <= 1'b1;
                end else begin
                    second_q <= 1'b0;
                    if (ctrl_w.reg_view.is_reg) begin
                        regs[ctrl_w.reg_view.reg_num] <= latch_q;
                    end else if (!ctrl_w.addr_view.write_mode) begin
                        // Read setup prefetches the first byte right away
                        rd_stb_q <= 1'b1;
                        ptr_q    <= setup_ptr + 17'd1;
                    end else begin
                        ptr_q <= setup_ptr;
                    end
                end
            end
        end
    end

    // Latched first byte, request address and data, read-ahead buffer
    always_ff @(posedge cpu_bus) begin
        if (ctrl_wr && !second_q) begin
            latch_q <= cpu.wdata;
        end
        if (data_wr || data_rd) begin
            cmd_addr_q <= ptr_q;
        end else if (ctrl_wr && second_q) begin
            cmd_addr_q <= setup_ptr;
        end
        if (data_wr) begin
            cmd_data_q <= cpu.wdata;
        end
        if (rd_valid) begin
            rd_buf_q <= rd_data;
        end
    end

    assign vram_cmd.wr_stb = wr_stb_q;
    assign vram_cmd.rd_stb = rd_stb_q;
    assign vram_cmd.addr   = cmd_addr_q;
    assign vram_cmd.data   = cmd_data_q;

    // Register 7 low nibble is the backdrop, register 1 bit 5 the vblank IE
    assign backdrop = regs[7][3:0];
    assign irq_en   = regs[1][5];

    a_one_strobe: assert property (
        @(posedge cpu_bus) disable iff (!arst_n) !(wr_stb_q && rd_stb_q)
    );

endmodule

`default_nettype wire

// File: hw/vdp_vram_port.sv
`default_nettype none

module vdp_vram_port (
    input  logic               cpu_bus,
    input  logic               arst_n,
    input  vdp_pkg::vram_cmd_t vram_cmd,
    input  logic [7:0]         q_lo,
    input  logic [7:0]         q_hi,
    output vdp_pkg::vram_bus_t vram,
    output logic [7:0]         rd_data,
    output logic               rd_valid
);

    logic rd_pend_q;
    logic rd_bank_q;

    // Address and data go straight out in the strobe cycle
    assign vram.addr = vram_cmd.addr[15:0];
    assign vram.data = vram_cmd.data;

    // Bit 16 of the pointer selects the bank that gets the write enable
    assign vram.we_lo = vram_cmd.wr_stb && !vram_cmd.addr[16];
    assign vram.we_hi = vram_cmd.wr_stb &&  vram_cmd.addr[16];

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            rd_pend_q <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            // The registered VRAM output is valid one clock after the strobe
            rd_pend_q <= vram_cmd.rd_stb;
            rd_valid  <= rd_pend_q;
        end
    end

    // Remember which lane the pending read belongs to and grab that byte
    always_ff @(posedge cpu_bus) begin
        if (vram_cmd.rd_stb) begin
            rd_bank_q <= vram_cmd.addr[16];
        end
        if (rd_pend_q) begin
            rd_data <= rd_bank_q ? q_hi : q_lo;
        end
    end

    a_one_bank: assert property (
        @(posedge cpu_bus) disable iff (!arst_n) !(vram.we_lo && vram.we_hi)
    );

endmodule

`default_nettype wire

// File: hw/vdp_video_gen.sv
`default_nettype none

module vdp_video_gen #(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 342,
    parameter int V_ACTIVE = 192,
    parameter int V_TOTAL  = 262
) (
    input  logic                cpu_bus,
    input  logic                arst_n,
    input  logic [3:0]          backdrop,
    output vdp_pkg::video_out_t video,
    output logic                vblank_start
);
    import vdp_pkg::*;

    // One spare bit so that H_ACTIVE + 8 still fits the compare
    localparam int HW = $clog2(H_TOTAL) + 1;
    localparam int VW = $clog2(V_TOTAL) + 1;

    localparam logic [HW-1:0] H_ACT  = HW'(H_ACTIVE);
    localparam logic [HW-1:0] H_LAST = HW'(H_TOTAL - 1);
    localparam logic [HW-1:0] HS_END = HW'(H_ACTIVE + 8);
    localparam logic [VW-1:0] V_ACT  = VW'(V_ACTIVE);
    localparam logic [VW-1:0] V_PRE  = VW'(V_ACTIVE - 1);
    localparam logic [VW-1:0] V_LAST = VW'(V_TOTAL - 1);

    logic          ce_q;
    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          hblank_raw;
    logic          hblank_q;
    logic          de;
    logic [23:0]   rgb;

    // Pixel clock enable on every second clock, counters move with it
    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            ce_q  <= 1'b0;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            ce_q <= !ce_q;
            if (ce_q) begin
                if (h_cnt == H_LAST) begin
                    h_cnt <= '0;
                    v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
                end else begin
                    h_cnt <= h_cnt + 1'b1;
                end
            end
        end
    end

    assign hblank_raw = (h_cnt >= H_ACT);
    assign de         = (h_cnt < H_ACT) && (v_cnt < V_ACT);

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            hblank_q     <= 1'b0;
            vblank_start <= 1'b0;
        end else begin
            // Stretch hblank up to the next pixel enable after the line starts
            if (hblank_raw) begin
                hblank_q <= 1'b1;
            end else if (ce_q) begin
                hblank_q <= 1'b0;
            end
            // Pulse in the first clock of line V_ACTIVE
            vblank_start <= ce_q && (h_cnt == H_LAST) && (v_cnt == V_PRE);
        end
    end

    assign rgb = PALETTE[backdrop];

    // Only the backdrop is drawn, black outside the active window
    assign video.r      = de ? rgb[23:16] : 8'd0;
    assign video.g      = de ? rgb[15:8]  : 8'd0;
    assign video.b      = de ? rgb[7:0]   : 8'd0;
    assign video.hs     = (h_cnt >= H_ACT) && (h_cnt < HS_END);
    assign video.vs     = (v_cnt == V_ACT);
    assign video.de     = de;
    assign video.hblank = hblank_raw || hblank_q;
    assign video.vblank = (v_cnt >= V_ACT);
    assign video.ce_pix = ce_q;

    a_no_de_in_vblank: assert property (
        @(posedge cpu_bus) disable iff (!arst_n) !(video.de && video.vblank)
    );

endmodule

`default_nettype wire

// File: hw/vdp_status_irq.sv
`default_nettype none

module vdp_status_irq (
    input  logic       cpu_bus,
    input  logic       arst_n,
    input  logic       vblank_start,
    input  logic       status_rd,
    input  logic       irq_en,
    output logic [7:0] status,
    output logic       interrupt
);

    logic flag_q;

    // A new frame wins over a status read in the same clock
    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            flag_q <= 1'b0;
        end else if (vblank_start) begin
            flag_q <= 1'b1;
        end else if (status_rd) begin
            flag_q <= 1'b0;
        end
    end

    // Only the frame flag is reported, sprite status is not modelled
    assign status = {flag_q, 7'd0};

    // Register 1 bit 5 masks the vblank interrupt
    assign interrupt = flag_q && irq_en;

    a_flag_after_vblank: assert property (
        @(posedge cpu_bus) disable iff (!arst_n) vblank_start |=> flag_q
    );

endmodule

`default_nettype wire

// File: hw/v99_device.sv
`default_nettype none

module v99_device #(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 342,
    parameter int V_ACTIVE = 192,
    parameter int V_TOTAL  = 262
) (
    input  logic                cpu_bus,
    input  logic                arst_n,
    input  vdp_pkg::cpu_req_t   cpu,
    input  vdp_pkg::io_device_t io_device,
    input  logic [7:0]          q_lo,
    input  logic [7:0]          q_hi,
    output logic [7:0]          rdata,
    output vdp_pkg::video_out_t video,
    output vdp_pkg::vram_bus_t  vram,
    output logic                interrupt
);
    import vdp_pkg::*;

    // Idle VRAM bus while the device is switched off
    localparam vram_bus_t VRAM_IDLE = '{addr: '1, data: '1, we_lo: 1'b0, we_hi: 1'b0};

    vram_cmd_t  vram_cmd;
    vram_bus_t  vram_int;
    video_out_t video_int;
    logic [7:0] rd_data;
    logic       rd_valid;
    logic [7:0] status;
    logic       status_rd;
    logic [3:0] backdrop;
    logic       irq_en;
    logic       vblank_start;
    logic       irq_int;

    vdp_cmd_port u_cmd_port (
        .cpu_bus   (cpu_bus),
        .arst_n    (arst_n),
        .cpu       (cpu),
        .io_device (io_device),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .status    (status),
        .rdata     (rdata),
        .status_rd (status_rd),
        .vram_cmd  (vram_cmd),
        .backdrop  (backdrop),
        .irq_en    (irq_en)
    );

    vdp_vram_port u_vram_port (
        .cpu_bus  (cpu_bus),
        .arst_n   (arst_n),
        .vram_cmd (vram_cmd),
        .q_lo     (q_lo),
        .q_hi     (q_hi),
        .vram     (vram_int),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    vdp_video_gen #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_video_gen (
        .cpu_bus      (cpu_bus),
        .arst_n       (arst_n),
        .backdrop     (backdrop),
        .video        (video_int),
        .vblank_start (vblank_start)
    );

    vdp_status_irq u_status_irq (
        .cpu_bus      (cpu_bus),
        .arst_n       (arst_n),
        .vblank_start (vblank_start),
        .status_rd    (status_rd),
        .irq_en       (irq_en),
        .status       (status),
        .interrupt    (irq_int)
    );

    // With the enable bit low the device looks absent on every bus
    assign video     = io_device.enable ? video_int : '0;
    assign vram      = io_device.enable ? vram_int : VRAM_IDLE;
    assign interrupt = io_device.enable && irq_int;

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD = 4
) (
    output logic cpu_bus,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // Free running 8 ns clock
    initial begin
        cpu_bus = 1'b0;
        forever begin
            #HALF_PERIOD cpu_bus = ~cpu_bus;
        end
    end

    // Reset is held for two full clock periods and released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (2) @(negedge cpu_bus);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_v99_checker.sv
`default_nettype none

module tb_v99_checker (
    input  logic                cpu_bus,
    input  logic                arst_n,
    input  vdp_pkg::io_device_t io_device,
    input  logic [7:0]          rdata,
    input  vdp_pkg::video_out_t video,
    input  vdp_pkg::vram_bus_t  vram,
    input  logic                interrupt,
    input  logic                chk_rdata,
    input  logic                chk_vram,
    input  logic                chk_irq,
    input  logic                chk_video,
    input  logic [31:0]         chk_exp,
    input  logic                test_end,
    input  int                  test_id,
    input  logic                all_done,
    output int                  errors
);
    timeunit 1ns;
    timeprecision 100ps;

    int   checks;
    int   test_checks;
    int   test_errs;
    int   tests_run;
    int   tests_failed;
    int   en_vid_cycles;
    int   de_cycles;
    int   hs_cycles;
    int   vs_cycles;
    logic last_ce;

    // Every compared value is widened to 32 bits by the caller
    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        test_checks++;
        if (exp !== got) begin
            $display("MISMATCH at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
            test_errs++;
            errors++;
        end
    endtask

    task automatic report(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        test_errs++;
        errors++;
    endtask

    task automatic check_video();
        logic [23:0] exp_rgb;
        if (!io_device.enable) begin
            // A switched off device shows no picture, no strobes and no interrupt
            compare("video", 32'd0, 32'(video));
            compare("vram.we", 32'd0, {30'd0, vram.we_hi, vram.we_lo});
            compare("interrupt", 32'd0, {31'd0, interrupt});
        end else begin
            en_vid_cycles++;
            if (video.de && video.vblank) begin
                report("de is high during vblank");
            end
            // The pixel enable alternates on every clock
            if (en_vid_cycles > 1) begin
                compare("video.ce_pix", {31'd0, !last_ce}, {31'd0, video.ce_pix});
            end
            last_ce = video.ce_pix;
            // Sync pulses lie inside the blanking intervals
            if (video.hs && (video.de || !video.hblank)) begin
                report("hs is high outside hblank");
            end
            if (video.vs && !video.vblank) begin
                report("vs is high outside vblank");
            end
            // A visible line is blanked wherever de is low
            if (!video.de && !video.vblank && !video.hblank) begin
                report("hblank is low outside de on a visible line");
            end
            if (video.hs) begin
                hs_cycles++;
            end
            if (video.vs) begin
                vs_cycles++;
            end
            // Backdrop colour inside the active window, black everywhere else
            exp_rgb = video.de ? chk_exp[23:0] : 24'd0;
            compare("video.rgb", {8'd0, exp_rgb}, {8'd0, video.r, video.g, video.b});
            if (video.de) begin
                de_cycles++;
            end
        end
    endtask

    task automatic close_test();
        tests_run++;
        if (en_vid_cycles > 0 && de_cycles == 0) begin
            report("no active pixels were seen during the video check");
        end
        if (en_vid_cycles > 0 && (hs_cycles == 0 || vs_cycles == 0)) begin
            report("no sync pulse was seen during the video check");
        end
        if (test_errs == 0) begin
            $display("test %0d passed, %0d checks", test_id, test_checks);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d errors in %0d checks", test_id, test_errs, test_checks);
        end
        test_checks   = 0;
        test_errs     = 0;
        en_vid_cycles = 0;
        de_cycles     = 0;
        hs_cycles     = 0;
        vs_cycles     = 0;
    endtask

    // Sampled on the rising edge, the testbench changes its inputs 1 ns later
    always @(posedge cpu_bus) begin
        if (arst_n && chk_rdata) begin
            compare("rdata", chk_exp, {24'd0, rdata});
        end
        if (arst_n && chk_vram) begin
            compare("vram", chk_exp, {6'd0, vram.we_hi, vram.we_lo, vram.addr, vram.data});
        end
        if (arst_n && chk_irq) begin
            compare("interrupt", chk_exp, {31'd0, interrupt});
        end
        if (arst_n && chk_video) begin
            check_video();
        end
        if (test_end) begin
            close_test();
        end
        if (all_done) begin
            $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                     tests_run, tests_failed, checks, errors);
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_v99.sv
`default_nettype none

module tb_v99;
    timeunit 1ns;
    timeprecision 100ps;
    import vdp_pkg::*;

    localparam int H_ACTIVE = 16;
    localparam int H_TOTAL  = 24;
    localparam int V_ACTIVE = 4;
    localparam int V_TOTAL  = 6;

    // One frame in clocks, the pixel enable runs at half the clock rate
    localparam int FRAME     = H_TOTAL * V_TOTAL * 2;
    localparam int VBL_LIMIT = 2 * FRAME;

    localparam logic [2:0] OP_CTRL_WR   = 3'd0;
    localparam logic [2:0] OP_DATA_WR   = 3'd1;
    localparam logic [2:0] OP_DATA_RD   = 3'd2;
    localparam logic [2:0] OP_STAT_RD   = 3'd3;
    localparam logic [2:0] OP_WAIT_VBL  = 3'd4;
    localparam logic [2:0] OP_CHK_VIDEO = 3'd5;
    localparam logic [2:0] OP_CHK_IRQ   = 3'd6;
    localparam logic [2:0] OP_SET_EN    = 3'd7;

    localparam logic [7:0]  D_PORT = 8'h98;
    localparam logic [7:0]  C_PORT = 8'h99;
    localparam logic [7:0]  X_PORT = 8'h88;
    localparam logic [31:0] ANY    = 32'hFFFF_FFFF;

    // Power-on colours of the chip, indexed by the backdrop nibble
    localparam logic [23:0] RGB_TABLE [16] = '{
        24'h000000, 24'h000000, 24'h24DB24, 24'h6DFF6D,
        24'h2424FF, 24'h496DFF, 24'hB62424, 24'h49DBFF,
        24'hFF2424, 24'hFF6D6D, 24'hDBDB24, 24'hDBDB92,
        24'h249224, 24'hDB49B6, 24'hB6B6B6, 24'hFFFFFF
    };

    typedef struct packed {
        logic [2:0]  op;
        logic [7:0]  port;
        logic [7:0]  data;
        logic [31:0] exp;
        int          test;
    } step_t;

    logic        cpu_bus;
    logic        arst_n;
    cpu_req_t    cpu;
    io_device_t  io_device;
    logic [7:0]  q_lo = 8'h00;
    logic [7:0]  q_hi = 8'h00;
    logic [7:0]  rdata;
    video_out_t  video;
    vram_bus_t   vram;
    logic        interrupt;
    logic        chk_rdata;
    logic        chk_vram;
    logic        chk_irq;
    logic        chk_video;
    logic [31:0] chk_exp;
    logic        test_end;
    int          test_id;
    logic        all_done;
    int          errors;
    logic        timed_out;
    step_t       steps [$];
    logic [7:0]  mem_lo [65536];
    logic [7:0]  mem_hi [65536];
    logic [7:0]  wbyte [4];
    logic [3:0]  bd;
    integer      seed;

    tb_clkgen u_clkgen (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n)
    );

    v99_device #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_dut (
        .cpu_bus   (cpu_bus),
        .arst_n    (arst_n),
        .cpu       (cpu),
        .io_device (io_device),
        .q_lo      (q_lo),
        .q_hi      (q_hi),
        .rdata     (rdata),
        .video     (video),
        .vram      (vram),
        .interrupt (interrupt)
    );

    tb_v99_checker u_checker (
        .cpu_bus   (cpu_bus),
        .arst_n    (arst_n),
        .io_device (io_device),
        .rdata     (rdata),
        .video     (video),
        .vram      (vram),
        .interrupt (interrupt),
        .chk_rdata (chk_rdata),
        .chk_vram  (chk_vram),
        .chk_irq   (chk_irq),
        .chk_video (chk_video),
        .chk_exp   (chk_exp),
        .test_end  (test_end),
        .test_id   (test_id),
        .all_done  (all_done),
        .errors    (errors)
    );

    // Two 64K banks with a registered read port, like synchronous block RAM
    always @(posedge cpu_bus) begin
        if (vram.we_lo) begin
            mem_lo[vram.addr] <= vram.data;
        end
        if (vram.we_hi) begin
            mem_hi[vram.addr] <= vram.data;
        end
        q_lo <= mem_lo[vram.addr];
        q_hi <= mem_hi[vram.addr];
    end

    task automatic add_step(input logic [2:0] op, input logic [7:0] port, input logic [7:0] data,
                            input logic [31:0] exp, input int test);
        steps.push_back('{op, port, data, exp, test});
    endtask

    task automatic run_step(input step_t s);
        int n;
        n = 0;
        case (s.op)
            OP_CTRL_WR, OP_DATA_WR, OP_DATA_RD, OP_STAT_RD: begin
                // One-cycle req, read data is compared in the req cycle itself
                cpu.req   = 1'b1;
                cpu.wr    = (s.op == OP_CTRL_WR) || (s.op == OP_DATA_WR);
                cpu.addr  = s.port;
                cpu.wdata = s.data;
                chk_exp   = s.exp;
                chk_rdata = !cpu.wr && (s.exp != ANY);
                @(posedge cpu_bus);
                #1;
                cpu.req   = 1'b0;
                chk_rdata = 1'b0;
                // A data write reaches the VRAM bus one cycle after the req
                chk_vram = (s.op == OP_DATA_WR);
                @(posedge cpu_bus);
                #1;
                chk_vram = 1'b0;
            end
            OP_WAIT_VBL: begin
                // Wait for a fresh rising edge of vblank
                while (video.vblank && n < VBL_LIMIT) begin
                    @(posedge cpu_bus);
                    #1;
                    n++;
                end
                while (!video.vblank && n < VBL_LIMIT) begin
                    @(posedge cpu_bus);
                    #1;
                    n++;
                end
                if (n >= VBL_LIMIT) begin
                    $display("ERROR at time %0t: no vblank within %0d cycles", $time, VBL_LIMIT);
                    timed_out = 1'b1;
                end
            end
            OP_CHK_VIDEO: begin
                // Watch a little more than one whole frame
                chk_exp   = s.exp;
                chk_video = 1'b1;
                repeat (FRAME + 8) @(posedge cpu_bus);
                #1;
                chk_video = 1'b0;
            end
            OP_CHK_IRQ: begin
                chk_exp = s.exp;
                chk_irq = 1'b1;
                @(posedge cpu_bus);
                #1;
                chk_irq = 1'b0;
            end
            OP_SET_EN: begin
                io_device.enable = s.data[0];
            end
        endcase
        // Two more idle cycles keep bus accesses four cycles apart
        repeat (2) @(posedge cpu_bus);
        #1;
    endtask

    task automatic finish_test(input int id);
        test_id  = id;
        test_end = 1'b1;
        @(posedge cpu_bus);
        #1;
        test_end = 1'b0;
    endtask

    initial begin
        int n;
        cpu       = '{req: 1'b0, wr: 1'b0, addr: 8'h00, wdata: 8'h00};
        io_device = '{enable: 1'b1, port: D_PORT, mask: 8'hFE};
        chk_rdata = 1'b0;
        chk_vram  = 1'b0;
        chk_irq   = 1'b0;
        chk_video = 1'b0;
        chk_exp   = 32'd0;
        test_end  = 1'b0;
        test_id   = 0;
        all_done  = 1'b0;
        timed_out = 1'b0;
        // Fill pattern mixes both address bytes, and the banks differ
        for (int a = 0; a < 65536; a++) begin
            mem_lo[a] = a[7:0] ^ a[15:8];
            mem_hi[a] = ~(a[7:0] ^ a[15:8]);
        end
        seed = 32'h1250;
        for (int k = 0; k < 4; k++) begin
            wbyte[k] = 8'($random(seed));
        end
        // Bit 1 set keeps the backdrop away from the two black entries
        bd = 4'($random(seed)) | 4'h2;

        // Writes at 0x0100 in the low bank, then register 14 moves them to 0x10200
        add_step(OP_CTRL_WR, C_PORT, 8'h00, ANY, 1);
        add_step(OP_CTRL_WR, C_PORT, 8'h41, ANY, 1);
        add_step(OP_DATA_WR, D_PORT, wbyte[0], {6'd0, 2'b01, 16'h0100, wbyte[0]}, 1);
        add_step(OP_DATA_WR, D_PORT, wbyte[1], {6'd0, 2'b01, 16'h0101, wbyte[1]}, 1);
        add_step(OP_CTRL_WR, C_PORT, 8'h04, ANY, 1);
        add_step(OP_CTRL_WR, C_PORT, 8'h8E, ANY, 1);
        add_step(OP_CTRL_WR, C_PORT, 8'h00, ANY, 1);
        add_step(OP_CTRL_WR, C_PORT, 8'h42, ANY, 1);
        add_step(OP_DATA_WR, D_PORT, wbyte[2], {6'd0, 2'b10, 16'h0200, wbyte[2]}, 1);
        add_step(OP_DATA_WR, D_PORT, wbyte[3], {6'd0, 2'b10, 16'h0201, wbyte[3]}, 1);
        // Read back the high bank, then the low bank with register 14 cleared
        add_step(OP_CTRL_WR, C_PORT, 8'h00, ANY, 2);
        add_step(OP_CTRL_WR, C_PORT, 8'h02, ANY, 2);
        add_step(OP_DATA_RD, D_PORT, 8'h00, {24'd0, wbyte[2]}, 2);
        add_step(OP_DATA_RD, D_PORT, 8'h00, {24'd0, wbyte[3]}, 2);
        add_step(OP_CTRL_WR, C_PORT, 8'h00, ANY, 2);
        add_step(OP_CTRL_WR, C_PORT, 8'h8E, ANY, 2);
        add_step(OP_CTRL_WR, C_PORT, 8'h00, ANY, 2);
        add_step(OP_CTRL_WR, C_PORT, 8'h01, ANY, 2);
        add_step(OP_DATA_RD, D_PORT, 8'h00, {24'd0, wbyte[0]}, 2);
        add_step(OP_DATA_RD, D_PORT, 8'h00, {24'd0, wbyte[1]}, 2);
        // Backdrop colour through register 7
        add_step(OP_CTRL_WR, C_PORT, {4'h0, bd}, ANY, 3);
        add_step(OP_CTRL_WR, C_PORT, 8'h87, ANY, 3);
        add_step(OP_CHK_VIDEO, D_PORT, 8'h00, {8'd0, RGB_TABLE[bd]}, 3);
        // Interrupt enabled, the first status read only clears an old flag
        add_step(OP_CTRL_WR, C_PORT, 8'h20, ANY, 4);
        add_step(OP_CTRL_WR, C_PORT, 8'h81, ANY, 4);
        add_step(OP_WAIT_VBL, D_PORT, 8'h00, ANY, 4);
        add_step(OP_STAT_RD, C_PORT, 8'h00, ANY, 4);
        add_step(OP_CHK_IRQ, D_PORT, 8'h00, 32'd0, 4);
        add_step(OP_WAIT_VBL, D_PORT, 8'h00, ANY, 4);
        add_step(OP_CHK_IRQ, D_PORT, 8'h00, 32'd1, 4);
        add_step(OP_STAT_RD, C_PORT, 8'h00, 32'h0000_0080, 4);
        add_step(OP_CHK_IRQ, D_PORT, 8'h00, 32'd0, 4);
        // Interrupt masked, the flag still shows in the status byte
        add_step(OP_CTRL_WR, C_PORT, 8'h00, ANY, 4);
        add_step(OP_CTRL_WR, C_PORT, 8'h81, ANY, 4);
        add_step(OP_WAIT_VBL, D_PORT, 8'h00, ANY, 4);
        add_step(OP_CHK_IRQ, D_PORT, 8'h00, 32'd0, 4);
        add_step(OP_STAT_RD, C_PORT, 8'h00, 32'h0000_0080, 4);
        // Foreign port, then the whole device switched off with the interrupt armed
        add_step(OP_DATA_RD, X_PORT, 8'h00, 32'h0000_00FF, 5);
        add_step(OP_CTRL_WR, C_PORT, 8'h20, ANY, 5);
        add_step(OP_CTRL_WR, C_PORT, 8'h81, ANY, 5);
        add_step(OP_SET_EN, D_PORT, 8'h00, ANY, 5);
        add_step(OP_DATA_RD, D_PORT, 8'h00, 32'h0000_00FF, 5);
        add_step(OP_STAT_RD, C_PORT, 8'h00, 32'h0000_00FF, 5);
        add_step(OP_DATA_WR, D_PORT, 8'h5A, 32'h00FF_FFFF, 5);
        add_step(OP_CHK_VIDEO, D_PORT, 8'h00, 32'd0, 5);
        add_step(OP_CHK_IRQ, D_PORT, 8'h00, 32'd0, 5);
        // Back on, the flag set while disabled reaches the pin again
        add_step(OP_SET_EN, D_PORT, 8'h01, ANY, 5);
        add_step(OP_CHK_IRQ, D_PORT, 8'h00, 32'd1, 5);

        n = 0;
        while (arst_n !== 1'b1 && n < 50) begin
            @(posedge cpu_bus);
            #1;
            n++;
        end
        if (arst_n !== 1'b1) begin
            $display("ERROR at time %0t: reset was never released", $time);
            timed_out = 1'b1;
        end
        @(posedge cpu_bus);
        #1;

        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            if (i > 0 && steps[i].test != steps[i - 1].test) begin
                finish_test(steps[i - 1].test);
            end
            run_step(steps[i]);
        end
        if (!timed_out) begin
            finish_test(steps[steps.size() - 1].test);
        end

        all_done = 1'b1;
        @(posedge cpu_bus);
        #1;
        all_done = 1'b0;
        @(posedge cpu_bus);
        #1;
        if (!timed_out && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: v99.f
hw/vdp_pkg.sv
hw/vdp_cmd_port.sv
hw/vdp_vram_port.sv
hw/vdp_video_gen.sv
hw/vdp_status_irq.sv
hw/v99_device.sv
dv/tb_clkgen.sv
dv/tb_v99_checker.sv
dv/tb_v99.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the v99 testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_v99 \
    -Mdir obj_dir -f v99.f \
    && ./obj_dir/Vtb_v99 | tee sim.log \
    || { echo "Build or simulation error"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
